//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+source
source/axi_lite_pkg.sv
source/eeprom_pkg.sv
source/eeprom_cmd_if.sv
source/i2c_byte_if.sv
source/eeprom_axi_regs.sv
source/eeprom_sequencer.sv
source/i2c_byte_engine.sv
source/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/tb_eeprom_ctrl.sv

//--- source/axi_lite_pkg.sv
package axi_lite_pkg;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- source/eeprom_axi_regs.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_axi_regs
    import axi_lite_pkg::*;
(
    input  logic             CLK,
    input  logic             RESET,
    input  logic [3:0]       awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  logic [31:0]      wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,
    output axi_resp_t        bresp,
    output logic             bvalid,
    input  logic             bready,
    input  logic [3:0]       araddr,
    input  logic             arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output axi_resp_t        rresp,
    output logic             rvalid,
    input  logic             rready,
    eeprom_cmd_if.regs       cmd
);

    logic                      init_done;
    logic                      wr_fire;
    logic                      rd_fire;
    logic                      eng_busy;
    logic [`EEPROM_ADDR_W-1:0] addr_q;
    logic [`EEPROM_DATA_W-1:0] wdata_q;
    logic [`EEPROM_DATA_W-1:0] rbyte_q;
    logic                      done_q;
    logic                      nack_q;

    // req counts as busy so a second CMD cannot slip in before busy rises
    assign eng_busy = cmd.busy | cmd.req;

    assign awready = init_done & ~bvalid & awvalid & wvalid;
    assign wready  = awready;
    assign arready = init_done & ~rvalid;
    assign wr_fire = awready;
    assign rd_fire = arvalid & arready;

    assign cmd.addr  = addr_q;
    assign cmd.wdata = wdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            init_done   <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= OKAY;
            rvalid      <= 1'b0;
            rresp       <= OKAY;
            rdata       <= '0;
            cmd.req     <= 1'b0;
            cmd.is_read <= 1'b0;
            addr_q      <= '0;
            wdata_q     <= '0;
            rbyte_q     <= '0;
            done_q      <= 1'b0;
            nack_q      <= 1'b0;
        end
        else
        begin
            init_done <= 1'b1;
            cmd.req   <= 1'b0;

            if (cmd.done)
            begin
                done_q  <= 1'b1;
                nack_q  <= cmd.nack;
                rbyte_q <= cmd.rdata;
            end

            if (bvalid && bready)
                bvalid <= 1'b0;
            if (rvalid && rready)
                rvalid <= 1'b0;

            if (wr_fire)
            begin
                bvalid <= 1'b1;
                bresp  <= OKAY;
                case (awaddr)
                    `REG_ADDR_OFS:
                    begin
                        if (wstrb[0])
                            addr_q[7:0] <= wdata[7:0];
                        if (wstrb[1])
                            addr_q[`EEPROM_ADDR_W-1:8] <= wdata[`EEPROM_ADDR_W-1:8];
                    end
                    `REG_WDATA_OFS:
                    begin
                        if (wstrb[0])
                            wdata_q <= wdata[`EEPROM_DATA_W-1:0];
                    end
                    `REG_CMD_OFS:
                    begin
                        if (eng_busy)
                            bresp <= SLVERR; // no effect while running
                        else
                        begin
                            done_q      <= 1'b0;
                            cmd.req     <= |wdata[1:0];
                            cmd.is_read <= wdata[1]; // read wins
                        end
                    end
                    default: bresp <= SLVERR; // status is read-only
                endcase
            end

            if (rd_fire)
            begin
                rvalid <= 1'b1;
                rresp  <= OKAY;
                case (araddr)
                    `REG_ADDR_OFS:   rdata <= 32'(addr_q);
                    `REG_WDATA_OFS:  rdata <= 32'(wdata_q);
                    `REG_CMD_OFS:    rdata <= '0;
                    `REG_STATUS_OFS: rdata <= {16'h0, rbyte_q, 5'h0, nack_q, done_q, eng_busy};
                    default:
                    begin
                        rdata <= '0;
                        rresp <= SLVERR;
                    end
                endcase
            end
        end
    end

endmodule

//--- source/eeprom_cmd_if.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

interface eeprom_cmd_if;

    logic                      req;
    logic                      is_read;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic                      busy;
    logic                      done;  // one cycle
    logic                      nack;  // valid with done
    logic [`EEPROM_DATA_W-1:0] rdata; // valid with done

    modport regs (
        output req, is_read, addr, wdata,
        input  busy, done, nack, rdata
    );

    modport seq (
        input  req, is_read, addr, wdata,
        output busy, done, nack, rdata
    );

endinterface

//--- source/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top
    import axi_lite_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        scl,
    output logic        sda_drive_low, // open drain, high pulls sda low
    input  logic        sda_in
);

    eeprom_cmd_if cmd_bus ();
    i2c_byte_if   byte_bus ();

    eeprom_axi_regs u_regs (
        .CLK     (CLK),
        .RESET   (RESET),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd_bus.regs)
    );

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .cmd   (cmd_bus.seq),
        .bus   (byte_bus.seq)
    );

    i2c_byte_engine u_eng (
        .CLK           (CLK),
        .RESET         (RESET),
        .bus           (byte_bus.eng),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

//--- source/eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8
`define EEPROM_SCL_QUARTER 2 // CLK cycles per quarter of SCL

`define REG_ADDR_OFS 4'h0
`define REG_WDATA_OFS 4'h4
`define REG_CMD_OFS 4'h8
`define REG_STATUS_OFS 4'hC

`endif

//--- source/eeprom_pkg.sv
`include "eeprom_macros.svh"

package eeprom_pkg;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // control byte, shifted raw but built from fields
    typedef union packed {
        logic [`EEPROM_DATA_W-1:0] raw;
        struct packed {
            logic [3:0] dev_code;
            logic [2:0] block; // address bits 10..8
            logic       rd;
        } f;
    } ctrl_byte_u;

    typedef enum logic [1:0] {
        START,
        STOP,
        SEND,
        RECV
    } byte_op_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR_W,
        S_DATA_W,
        S_RESTART, // repeated start of a random read
        S_CTRL_R,
        S_DATA_R,
        S_STOP
    } seq_state_t;

endpackage

//--- source/eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    eeprom_cmd_if.seq cmd,
    i2c_byte_if.seq   bus
);

    seq_state_t                state;
    seq_state_t                nxt;
    logic                      is_read_q;
    logic [`EEPROM_ADDR_W-1:0] addr_q;
    logic [`EEPROM_DATA_W-1:0] wdata_q;
    logic                      op_done;
    logic                      ack_fail;

    function automatic byte_op_t op_of(seq_state_t s);
        case (s)
            S_START, S_RESTART: return START;
            S_STOP:             return STOP;
            S_DATA_R:           return RECV;
            default:            return SEND;
        endcase
    endfunction

    function automatic logic [`EEPROM_DATA_W-1:0] tx_of(seq_state_t s);
        ctrl_byte_u ctrl;
        ctrl.f.dev_code = DEV_CODE;
        ctrl.f.block    = addr_q[`EEPROM_ADDR_W-1:8];
        ctrl.f.rd       = (s == S_CTRL_R);
        case (s)
            S_CTRL_W, S_CTRL_R: return ctrl.raw;
            S_ADDR_W:           return addr_q[7:0];
            S_DATA_W:           return wdata_q;
            default:            return '0;
        endcase
    endfunction

    // ready falls the cycle after go, so ready with go low means finished
    assign op_done  = (state != S_IDLE) && !bus.go && bus.ready;
    assign ack_fail = !bus.ack_ok && ((state == S_CTRL_W) || (state == S_ADDR_W) ||
                                      (state == S_DATA_W) || (state == S_CTRL_R));

    always_comb
    begin
        case (state)
            S_START:   nxt = S_CTRL_W;
            S_CTRL_W:  nxt = S_ADDR_W;
            S_ADDR_W:  nxt = is_read_q ? S_RESTART : S_DATA_W;
            S_DATA_W:  nxt = S_STOP;
            S_RESTART: nxt = S_CTRL_R;
            S_CTRL_R:  nxt = S_DATA_R;
            S_DATA_R:  nxt = S_STOP;
            default:   nxt = S_IDLE;
        endcase
        if (ack_fail)
            nxt = S_STOP; // abort, still release the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            bus.go   <= 1'b0;
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
            cmd.nack <= 1'b0;
        end
        else
        begin
            bus.go   <= 1'b0;
            cmd.done <= 1'b0;
            if (state == S_IDLE)
            begin
                if (cmd.req)
                begin
                    state    <= S_START;
                    bus.go   <= 1'b1;
                    cmd.busy <= 1'b1;
                    cmd.nack <= 1'b0;
                end
            end
            else if (op_done)
            begin
                state <= nxt;
                if (ack_fail)
                    cmd.nack <= 1'b1;
                if (state == S_STOP)
                begin
                    cmd.busy <= 1'b0;
                    cmd.done <= 1'b1;
                end
                else
                    bus.go <= 1'b1; // next op right away
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && cmd.req)
        begin
            addr_q    <= cmd.addr;
            wdata_q   <= cmd.wdata;
            is_read_q <= cmd.is_read;
            bus.op    <= START;
        end
        else if (op_done && state != S_STOP)
        begin
            bus.op      <= op_of(nxt);
            bus.tx_byte <= tx_of(nxt);
        end

        if (op_done && state == S_DATA_R)
            cmd.rdata <= bus.rx_byte;
    end

endmodule

//--- source/i2c_byte_engine.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_byte_engine
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    i2c_byte_if.eng bus,
    output logic    scl,
    output logic    sda_drive_low,
    input  logic    sda_in
);

    localparam int DIV_W = $clog2(`EEPROM_SCL_QUARTER + 1);
    localparam int BIT_W = $clog2(`EEPROM_DATA_W + 1);

    logic                      active;
    byte_op_t                  op_q;
    logic [DIV_W-1:0]          div;
    logic [1:0]                qtr;     // quarter of the current bit
    logic [BIT_W-1:0]          bit_cnt; // 0..7 data, 8 ack
    logic [`EEPROM_DATA_W-1:0] shift;
    logic [`EEPROM_DATA_W-1:0] rx_shift;
    logic                      tick;
    logic                      ack_bit;
    logic                      sample;
    logic                      scl_nxt;
    logic                      sdl_nxt;

    assign tick    = (div == DIV_W'(`EEPROM_SCL_QUARTER - 1));
    assign ack_bit = (bit_cnt == BIT_W'(`EEPROM_DATA_W));
    assign sample  = tick && (qtr == 2'd2); // end of the high phase

    assign bus.ready   = ~active;
    assign bus.rx_byte = rx_shift;

    // line levels for the current quarter
    always_comb
    begin
        scl_nxt = (qtr == 2'd1) || (qtr == 2'd2);
        case (op_q)
            START:   sdl_nxt = qtr[1]; // falls while scl high
            STOP:
            begin
                scl_nxt = (qtr != 2'd0);
                sdl_nxt = ~qtr[1]; // rises while scl high
            end
            SEND:    sdl_nxt = !ack_bit && !shift[`EEPROM_DATA_W-1];
            default: sdl_nxt = 1'b0; // recv, nack on bit 9 too
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            op_q          <= START;
            div           <= '0;
            qtr           <= '0;
            bit_cnt       <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            bus.ack_ok    <= 1'b0;
        end
        else if (!active)
        begin
            if (bus.go)
            begin
                active  <= 1'b1;
                op_q    <= bus.op;
                div     <= '0;
                qtr     <= '0;
                bit_cnt <= '0;
            end
        end
        else
        begin
            scl           <= scl_nxt;
            sda_drive_low <= sdl_nxt;
            div           <= tick ? '0 : div + 1'b1;
            if (sample && op_q == SEND && ack_bit)
                bus.ack_ok <= !sda_in;
            if (tick)
            begin
                qtr <= qtr + 1'b1;
                if (qtr == 2'd3)
                begin
                    if (op_q == START || op_q == STOP || ack_bit)
                        active <= 1'b0;
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && bus.go)
            shift <= bus.tx_byte;
        else if (active && tick && qtr == 2'd3)
            shift <= shift << 1; // msb first
        if (active && sample && op_q == RECV && !ack_bit)
            rx_shift <= {rx_shift[`EEPROM_DATA_W-2:0], sda_in};
    end

endmodule

//--- source/i2c_byte_if.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

interface i2c_byte_if
    import eeprom_pkg::*;
();

    logic                      go;
    byte_op_t                  op;
    logic [`EEPROM_DATA_W-1:0] tx_byte;
    logic                      ready;
    logic [`EEPROM_DATA_W-1:0] rx_byte;
    logic                      ack_ok; // slave pulled sda low on bit 9

    modport seq (
        output go, op, tx_byte,
        input  ready, rx_byte, ack_ok
    );

    modport eng (
        input  go, op, tx_byte,
        output ready, rx_byte, ack_ok
    );

endinterface

//--- verification/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,       // resolved line
    input  logic no_ack,    // ignore the device code
    output logic drive_low
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_TX
    } mode_t;

    // erased array
    logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1] = '{default: 8'hFF};

    mode_t                     mode;
    logic                      scl_q;
    logic                      sda_q;
    logic [3:0]                bit_cnt; // rising scl edges in this byte
    logic [`EEPROM_DATA_W-1:0] shift;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic                      rd;
    logic                      start_seen;
    logic                      stop_seen;
    logic                      rise;
    logic                      fall;

    assign start_seen = scl_q && scl && sda_q && !sda;
    assign stop_seen  = scl_q && scl && !sda_q && sda;
    assign rise       = !scl_q && scl;
    assign fall       = scl_q && !scl;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            mode      <= M_IDLE;
            bit_cnt   <= 4'd0;
            drive_low <= 1'b0;
        end
        else if (start_seen)
        begin
            mode      <= M_CTRL;
            bit_cnt   <= 4'd0;
            drive_low <= 1'b0;
        end
        else if (stop_seen)
        begin
            mode      <= M_IDLE;
            drive_low <= 1'b0;
        end
        else if (rise && mode != M_IDLE)
        begin
            if (mode != M_TX && bit_cnt < 4'd8)
                shift <= {shift[`EEPROM_DATA_W-2:0], sda};
            bit_cnt <= bit_cnt + 4'd1;
        end
        else if (fall && bit_cnt == 4'd8)
        begin
            case (mode)
                M_CTRL:
                begin
                    if (shift[7:4] == 4'b1010 && !no_ack)
                    begin
                        drive_low  <= 1'b1;
                        addr[10:8] <= shift[3:1];
                        rd         <= shift[0];
                    end
                    else
                        mode <= M_IDLE; // not for us
                end
                M_ADDR:
                begin
                    drive_low <= 1'b1;
                    addr[7:0] <= shift;
                end
                M_DATA:
                begin
                    drive_low <= 1'b1;
                    mem[addr] <= shift;
                    addr[7:0] <= addr[7:0] + 8'd1;
                end
                default: drive_low <= 1'b0; // master's ack slot
            endcase
        end
        else if (fall && bit_cnt == 4'd9)
        begin
            bit_cnt   <= 4'd0;
            drive_low <= 1'b0;
            case (mode)
                M_CTRL:
                begin
                    if (rd)
                    begin
                        mode      <= M_TX;
                        shift     <= mem[addr];
                        drive_low <= !mem[addr][7];
                    end
                    else
                        mode <= M_ADDR;
                end
                M_ADDR, M_DATA: mode <= M_DATA;
                default:        mode <= M_IDLE; // read ends after one byte
            endcase
        end
        else if (fall && mode == M_TX && bit_cnt != 4'd0)
        begin
            shift     <= shift << 1;
            drive_low <= !shift[6];
        end
    end

endmodule

//--- verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module tb_eeprom_ctrl
    import axi_lite_pkg::*;
();

    // about 40 bus operations of up to 400 cycles each, plus margin
    localparam int MAX_CYCLES = 40 * 400 + 4000;

    logic        CLK = 1'b0;
    logic        RESET;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;
    logic        scl;
    logic        sda_drive_low;
    logic        model_drive_low;
    logic        sda;
    logic        no_ack;
    int          cycle_cnt = 0;
    logic [7:0]  shadow [0:(1 << `EEPROM_ADDR_W)-1] = '{default: 8'hFF};

    assign sda = !sda_drive_low && !model_drive_low; // wired-AND of both open drains

    eeprom_ctrl_top dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model model (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .no_ack    (no_ack),
        .drive_low (model_drive_low)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES)
        begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // expected eeprom contents, erased cells read 0xff
    function automatic logic [7:0] ref_mem(input logic wr, input logic [10:0] a,
                                           input logic [7:0] d);
        if (wr)
            shadow[a] = d;
        return shadow[a];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // hold > 0 keeps bready low for that many cycles after bvalid
    task automatic axi_write(input logic [3:0] ofs, input logic [31:0] data, input int hold,
                             output axi_resp_t resp);
        @(posedge CLK);
        awaddr  <= ofs;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        @(posedge CLK);
        while (!awready)
        begin
            compare("wready before acceptance", 32'h0, 32'(wready));
            @(posedge CLK);
        end
        compare("wready at acceptance", 32'h1, 32'(wready)); // address and data go together
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge CLK);
        while (!bvalid)
            @(posedge CLK);
        resp = bresp;
        repeat (hold)
        begin
            @(posedge CLK);
            compare("bvalid under back-pressure", 32'h1, 32'(bvalid));
            compare("bresp under back-pressure", 32'(resp), 32'(bresp));
        end
        if (hold != 0)
        begin
            bready <= 1'b1;
            @(posedge CLK); // handshake here
        end
    endtask

    task automatic axi_read(input logic [3:0] ofs, input int hold, output logic [31:0] data,
                            output axi_resp_t resp);
        @(posedge CLK);
        araddr  <= ofs;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        @(posedge CLK);
        while (!arready)
            @(posedge CLK);
        arvalid <= 1'b0;
        @(posedge CLK);
        while (!rvalid)
            @(posedge CLK);
        data = rdata;
        resp = rresp;
        repeat (hold)
        begin
            @(posedge CLK);
            compare("rvalid under back-pressure", 32'h1, 32'(rvalid));
            compare("arready under back-pressure", 32'h0, 32'(arready));
            compare("rdata under back-pressure", data, rdata);
            compare("rresp under back-pressure", 32'(resp), 32'(rresp));
        end
        if (hold != 0)
        begin
            rready <= 1'b1;
            @(posedge CLK);
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        axi_resp_t resp;
        status = '0;
        while (!status[1])
        begin
            axi_read(`REG_STATUS_OFS, 0, status, resp);
            compare("STATUS read response", 32'(OKAY), 32'(resp));
        end
    endtask

    task automatic run_op(input logic rd, input logic [10:0] a, input logic [7:0] d,
                          output logic [31:0] status);
        axi_resp_t resp;
        axi_write(`REG_ADDR_OFS, 32'(a), 0, resp);
        compare("ADDR write response", 32'(OKAY), 32'(resp));
        axi_write(`REG_WDATA_OFS, 32'(d), 0, resp);
        compare("WDATA write response", 32'(OKAY), 32'(resp));
        axi_write(`REG_CMD_OFS, rd ? 32'h2 : 32'h1, 0, resp);
        compare("CMD write response", 32'(OKAY), 32'(resp));
        wait_done(status);
    endtask

    initial
    begin
        logic [31:0] status;
        logic [31:0] value;
        axi_resp_t   resp;
        logic [10:0] a;
        logic [10:0] last_a;
        logic [7:0]  d;
        logic [7:0]  expected;
        int          i;

        void'($urandom(32'h3b8c));
        RESET   <= 1'b1;
        awaddr  <= 4'h0;
        awvalid <= 1'b0;
        wdata   <= 32'h0;
        wstrb   <= 4'hF;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        araddr  <= 4'h0;
        arvalid <= 1'b0;
        rready  <= 1'b1;
        no_ack  <= 1'b0;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        compare("reset scl", 32'h1, 32'(scl)); // bus idle
        compare("reset sda_drive_low", 32'h0, 32'(sda_drive_low));

        axi_read(`REG_STATUS_OFS, 0, value, resp);
        compare("reset status flags", 32'h0, value & 32'h7);
        compare("reset STATUS response", 32'(OKAY), 32'(resp));
        axi_read(`REG_ADDR_OFS, 0, value, resp);
        compare("reset ADDR", 32'h0, value);
        compare("reset ADDR response", 32'(OKAY), 32'(resp));
        axi_read(`REG_WDATA_OFS, 0, value, resp);
        compare("reset WDATA", 32'h0, value);
        compare("reset WDATA response", 32'(OKAY), 32'(resp));

        // one write and read back per block of bits 10..8
        for (i = 0; i < 8; i++)
        begin
            a = {3'(i), 8'($urandom)};
            d = 8'($urandom);
            run_op(1'b0, a, d, status);
            compare("block write nack", 32'h0, 32'(status[2]));
            compare("block write array", 32'(d), 32'(model.mem[a]));
            expected = ref_mem(1'b1, a, d);
            run_op(1'b1, a, 8'h00, status);
            compare("block read nack", 32'h0, 32'(status[2]));
            compare("block read data", 32'(expected), 32'(status[15:8]));
        end

        last_a = a;
        for (i = 0; i < 20; i++)
        begin
            a = ($urandom % 2 == 0) ? last_a : 11'($urandom);
            if ($urandom % 2 == 0)
            begin
                d = 8'($urandom);
                run_op(1'b0, a, d, status);
                compare("random write nack", 32'h0, 32'(status[2]));
                void'(ref_mem(1'b1, a, d));
                last_a = a;
            end
            else
            begin
                run_op(1'b1, a, 8'h00, status);
                compare("random read nack", 32'h0, 32'(status[2]));
                compare("random read data", 32'(ref_mem(1'b0, a, 8'h00)), 32'(status[15:8]));
            end
        end

        // second command while the first is still on the bus
        a = 11'($urandom);
        d = 8'($urandom);
        axi_write(`REG_ADDR_OFS, 32'(a), 0, resp);
        axi_write(`REG_WDATA_OFS, 32'(d), 0, resp);
        axi_write(`REG_CMD_OFS, 32'h1, 0, resp);
        compare("first CMD response", 32'(OKAY), 32'(resp));
        axi_write(`REG_CMD_OFS, 32'h2, 0, resp);
        compare("CMD while busy", 32'(SLVERR), 32'(resp));
        wait_done(status);
        compare("running write nack", 32'h0, 32'(status[2]));
        compare("running write array", 32'(d), 32'(model.mem[a]));
        void'(ref_mem(1'b1, a, d));
        last_a = a;
        axi_write(4'h6, 32'h1, 0, resp);
        compare("unmapped write response", 32'(SLVERR), 32'(resp));
        axi_read(4'h6, 0, value, resp);
        compare("unmapped read response", 32'(SLVERR), 32'(resp));
        compare("unmapped read data", 32'h0, value);

        @(posedge CLK);
        no_ack <= 1'b1;
        a = last_a;
        d = ~ref_mem(1'b0, a, 8'h00);
        run_op(1'b0, a, d, status);
        compare("nack write flags", 32'h6, status & 32'h7); // done and nack, not busy
        compare("nack write array", 32'(ref_mem(1'b0, a, 8'h00)), 32'(model.mem[a]));
        run_op(1'b1, a, 8'h00, status);
        compare("nack read flags", 32'h6, status & 32'h7);
        @(posedge CLK);
        no_ack <= 1'b0;

        a = 11'($urandom);
        axi_write(`REG_ADDR_OFS, 32'(a), int'($urandom % 8) + 1, resp);
        compare("held ADDR write response", 32'(OKAY), 32'(resp));
        axi_read(`REG_ADDR_OFS, int'($urandom % 8) + 1, value, resp);
        compare("held ADDR read data", 32'(a), value);
        compare("held ADDR read response", 32'(OKAY), 32'(resp));
        axi_read(`REG_STATUS_OFS, int'($urandom % 8) + 1, value, resp);
        compare("held STATUS flags", 32'h6, value & 32'h7);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
